// ==== src/procPkg.sv ====
`default_nettype none

package procPkg;

    localparam int dataW = 16;

    // Stores to this address go to the output port, not to data memory
    localparam logic [dataW-1:0] ioAddr = 16'hFF00;

    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJr    = 5'b00101,
        opJal   = 5'b00110,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opBltz  = 5'b01110,
        opBgez  = 5'b01111,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opSlbi  = 5'b10010,
        opLbi   = 5'b11000,
        opShift = 5'b11010,
        opAlu   = 5'b11011,
        opSeq   = 5'b11100,
        opSlt   = 5'b11101
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluAndn,
        aluSll, aluSrl, aluRol, aluRor,
        aluSeq, aluSlt, aluPassB, aluLbiShift
    } aluOpT;

    // Destination field: I-format 1 uses [7:5], R-format [4:2], I-format 2 [10:8]
    typedef enum logic [1:0] {dstI1, dstR, dstRs, dstR7} regDstT;
    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;
    typedef enum logic [1:0] {imm5, imm8, imm11} immSelT;

    typedef struct packed {
        regDstT regDst;
        logic   regWrite;
        logic   aluSrc;
        logic   memRead;
        logic   memWrite;
        wbSelT  wbSel;
        logic   branch;
        logic   jump;
        logic   jumpReg;
        logic   halt;
        immSelT immSel;
        logic   zeroExt;
    } ctrlT;

endpackage

`default_nettype wire

// ==== src/fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch #(
    parameter int imemWords = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         progWe,
    input  logic [$clog2(imemWords)-1:0] progAddr,
    input  logic [procPkg::dataW-1:0]    progData,
    input  logic [procPkg::dataW-1:0]    pc,
    input  logic                         halt,
    input  logic                         errIn,
    output logic [procPkg::dataW-1:0]    instr,
    output logic [procPkg::dataW-1:0]    pcNext,
    output logic                         halted,
    output logic                         err
);
    import procPkg::*;

    localparam int addrW = $clog2(imemWords);

    logic [dataW-1:0] pcQ;
    logic [dataW-1:0] imem [imemWords];
    logic             pcOdd;

    // PC holds while HALT sits at it, so the core stays frozen
    always_ff @(posedge clk) begin
        if (rst) begin
            pcQ <= '0;
        end else if (!halt) begin
            pcQ <= pc;
        end
    end

    // Boot-load port, open only while in reset
    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    assign instr  = imem[pcQ[addrW:1]];
    assign pcNext = pcQ + dataW'(2);
    assign pcOdd  = pcQ[0];

    // Sticky status for the whole core
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else begin
            halted <= halted | halt;
            err    <= err | errIn | pcOdd;
        end
    end

endmodule

`default_nettype wire

// ==== src/control.sv ====
`timescale 1ns/10ps
`default_nettype none

module control (
    input  procPkg::opcodeT opcode,
    output procPkg::ctrlT   ctrl,
    output logic            err
);
    import procPkg::*;

    always_comb begin
        ctrl = '0;
        err  = 1'b0;
        case (opcode)
            opHalt: begin
                ctrl.halt = 1'b1;
            end
            // Bundle stays all zero
            opNop: ;
            opAddi, opSubi, opXori, opAndni: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regDst   = dstI1;
                ctrl.immSel   = imm5;
                // Logic immediates are zero extended
                ctrl.zeroExt  = (opcode == opXori) || (opcode == opAndni);
            end
            opAlu, opShift, opSeq, opSlt: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstR;
            end
            opSt: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSel   = imm5;
            end
            opLd: begin
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regDst   = dstI1;
                ctrl.wbSel    = wbMem;
                ctrl.immSel   = imm5;
            end
            opLbi, opSlbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regDst   = dstRs;
                ctrl.immSel   = imm8;
                ctrl.zeroExt  = (opcode == opSlbi);
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                ctrl.branch = 1'b1;
                ctrl.immSel = imm8;
            end
            opJ: begin
                ctrl.jump   = 1'b1;
                ctrl.immSel = imm11;
            end
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.immSel   = imm11;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstR7;
                ctrl.wbSel    = wbLink;
            end
            opJr: begin
                ctrl.jumpReg = 1'b1;
                ctrl.immSel  = imm8;
            end
            default: begin
                // Unknown opcode, nothing gets written
                err = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [procPkg::dataW-1:0] instr,
    input  procPkg::ctrlT             ctrl,
    input  logic [procPkg::dataW-1:0] aluRes,
    input  logic [procPkg::dataW-1:0] memData,
    input  logic [procPkg::dataW-1:0] pcNext,
    output logic [procPkg::dataW-1:0] readData1,
    output logic [procPkg::dataW-1:0] readData2,
    output logic [procPkg::dataW-1:0] immVal
);
    import procPkg::*;

    logic [dataW-1:0] regs [8];
    logic [2:0]       rsIdx;
    logic [2:0]       rtIdx;
    logic [2:0]       dstIdx;
    logic [dataW-1:0] wbData;

    assign rsIdx = instr[10:8];
    assign rtIdx = instr[7:5];

    always_comb begin
        case (ctrl.regDst)
            dstI1:   dstIdx = instr[7:5];
            dstR:    dstIdx = instr[4:2];
            dstRs:   dstIdx = instr[10:8];
            default: dstIdx = 3'd7;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            wbMem:   wbData = memData;
            wbLink:  wbData = pcNext;
            default: wbData = aluRes;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regs[dstIdx] <= wbData;
        end
    end

    assign readData1 = regs[rsIdx];
    assign readData2 = regs[rtIdx];

    always_comb begin
        case (ctrl.immSel)
            imm5:    immVal = ctrl.zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
            imm8:    immVal = ctrl.zeroExt ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
            default: immVal = {{5{instr[10]}}, instr[10:0]};
        endcase
    end

endmodule

`default_nettype wire

// ==== src/execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  logic [procPkg::dataW-1:0] instr,
    input  procPkg::ctrlT             ctrl,
    input  logic [procPkg::dataW-1:0] readData1,
    input  logic [procPkg::dataW-1:0] readData2,
    input  logic [procPkg::dataW-1:0] immVal,
    output logic [procPkg::dataW-1:0] aluRes,
    output logic                      zero,
    output logic                      neg
);
    import procPkg::*;

    opcodeT             opcode;
    aluOpT              aluOp;
    logic [1:0]         funct;
    logic [dataW-1:0]   opA;
    logic [dataW-1:0]   opB;
    logic [3:0]         shamt;
    logic [2*dataW-1:0] rolTmp;
    logic [2*dataW-1:0] rorTmp;

    assign opcode = opcodeT'(instr[15:11]);
    assign funct  = instr[1:0];
    assign opA    = readData1;
    assign opB    = ctrl.aluSrc ? immVal : readData2;
    assign shamt  = opB[3:0];

    always_comb begin
        case (opcode)
            opAddi, opLd, opSt: aluOp = aluAdd;
            opSubi:             aluOp = aluSub;
            opXori:             aluOp = aluXor;
            opAndni:            aluOp = aluAndn;
            opSeq:              aluOp = aluSeq;
            opSlt:              aluOp = aluSlt;
            opSlbi:             aluOp = aluLbiShift;
            opAlu: begin
                case (funct)
                    2'b00:   aluOp = aluAdd;
                    2'b01:   aluOp = aluSub;
                    2'b10:   aluOp = aluXor;
                    default: aluOp = aluAndn;
                endcase
            end
            opShift: begin
                case (funct)
                    2'b00:   aluOp = aluRol;
                    2'b01:   aluOp = aluSll;
                    2'b10:   aluOp = aluRor;
                    default: aluOp = aluSrl;
                endcase
            end
            default:            aluOp = aluPassB;
        endcase
    end

    // Rotates from a doubled operand
    assign rolTmp = {opA, opA} << shamt;
    assign rorTmp = {opA, opA} >> shamt;

    always_comb begin
        case (aluOp)
            aluAdd:      aluRes = opA + opB;
            // ISA subtracts Rs from the second operand
            aluSub:      aluRes = opB - opA;
            aluXor:      aluRes = opA ^ opB;
            aluAndn:     aluRes = opA & ~opB;
            aluSll:      aluRes = opA << shamt;
            aluSrl:      aluRes = opA >> shamt;
            aluRol:      aluRes = rolTmp[2*dataW-1:dataW];
            aluRor:      aluRes = rorTmp[dataW-1:0];
            aluSeq:      aluRes = dataW'(opA == opB);
            aluSlt:      aluRes = dataW'($signed(opA) < $signed(opB));
            aluLbiShift: aluRes = (opA << 8) | opB;
            default:     aluRes = opB;
        endcase
    end

    // Branch flags look at Rs only
    assign zero = (readData1 == '0);
    assign neg  = readData1[dataW-1];

endmodule

`default_nettype wire

// ==== src/dataMem.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataMem #(
    parameter int dmemWords = 256
) (
    input  logic                      clk,
    input  logic                      rst,
    input  procPkg::ctrlT             ctrl,
    input  logic                      halt,
    input  logic [procPkg::dataW-1:0] aluRes,
    input  logic [procPkg::dataW-1:0] writeData,
    output logic [procPkg::dataW-1:0] memData,
    output logic                      ioValid,
    output logic [procPkg::dataW-1:0] ioData,
    output logic                      err
);
    import procPkg::*;

    localparam int addrW = $clog2(dmemWords);

    logic [dataW-1:0] mem [dmemWords];
    logic [addrW-1:0] wordAddr;
    logic             isIo;
    logic             misaligned;
    logic             doStore;

    assign wordAddr   = aluRes[addrW:1];
    assign isIo       = (aluRes == ioAddr);
    assign misaligned = aluRes[0] & (ctrl.memRead | ctrl.memWrite);
    // Odd stores are dropped
    assign doStore    = ctrl.memWrite & ~halt & ~misaligned;

    always_ff @(posedge clk) begin
        if (!rst && doStore && !isIo) begin
            mem[wordAddr] <= writeData;
        end
    end

    assign memData = mem[wordAddr];

    // Output device, one pulse per store
    always_ff @(posedge clk) begin
        if (rst) begin
            ioValid <= 1'b0;
        end else begin
            ioValid <= doStore & isIo;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst && doStore && isIo) begin
            ioData <= writeData;
        end
    end

    assign err = misaligned;

endmodule

`default_nettype wire

// ==== src/pcControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pcControl (
    input  logic [procPkg::dataW-1:0] instr,
    input  procPkg::ctrlT             ctrl,
    input  logic [procPkg::dataW-1:0] pcNext,
    input  logic [procPkg::dataW-1:0] immVal,
    input  logic [procPkg::dataW-1:0] readData1,
    input  logic                      zero,
    input  logic                      neg,
    output logic [procPkg::dataW-1:0] pc
);
    import procPkg::*;

    opcodeT           opcode;
    logic             taken;
    logic [dataW-1:0] relTarget;
    logic [dataW-1:0] regTarget;

    assign opcode = opcodeT'(instr[15:11]);

    always_comb begin
        case (opcode)
            opBeqz:  taken = zero;
            opBnez:  taken = ~zero;
            opBltz:  taken = neg;
            opBgez:  taken = ~neg;
            default: taken = 1'b0;
        endcase
    end

    // immVal is already 8 or 11 bits wide per immSel
    assign relTarget = pcNext + immVal;
    assign regTarget = readData1 + immVal;

    always_comb begin
        if (ctrl.jumpReg) begin
            pc = regTarget;
        end else if (ctrl.jump || (ctrl.branch && taken)) begin
            pc = relTarget;
        end else begin
            pc = pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/proc.sv ====
`timescale 1ns/10ps
`default_nettype none

module proc #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         progWe,
    input  logic [$clog2(imemWords)-1:0] progAddr,
    input  logic [procPkg::dataW-1:0]    progData,
    output logic                         ioValid,
    output logic [procPkg::dataW-1:0]    ioData,
    output logic                         halted,
    output logic                         err
);
    import procPkg::*;

    ctrlT             ctrl;
    logic [dataW-1:0] instr;
    logic [dataW-1:0] pcNext;
    logic [dataW-1:0] pc;
    logic [dataW-1:0] readData1;
    logic [dataW-1:0] readData2;
    logic [dataW-1:0] immVal;
    logic [dataW-1:0] aluRes;
    logic [dataW-1:0] memData;
    logic             zero;
    logic             neg;
    logic             ctrlErr;
    logic             memErr;
    logic             blockErr;

    // Fetch folds in its own odd-PC check and holds the sticky flag
    assign blockErr = ctrlErr | memErr;

    fetch #(.imemWords(imemWords)) fetch0 (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .halt(ctrl.halt), .errIn(blockErr), .instr(instr), .pcNext(pcNext),
        .halted(halted), .err(err)
    );

    control control0 (.opcode(opcodeT'(instr[15:11])), .ctrl(ctrl), .err(ctrlErr));

    decode decode0 (
        .clk(clk), .rst(rst), .instr(instr), .ctrl(ctrl), .aluRes(aluRes),
        .memData(memData), .pcNext(pcNext), .readData1(readData1),
        .readData2(readData2), .immVal(immVal)
    );

    execute exec0 (
        .instr(instr), .ctrl(ctrl), .readData1(readData1), .readData2(readData2),
        .immVal(immVal), .aluRes(aluRes), .zero(zero), .neg(neg)
    );

    dataMem #(.dmemWords(dmemWords)) memory0 (
        .clk(clk), .rst(rst), .ctrl(ctrl), .halt(halted), .aluRes(aluRes),
        .writeData(readData2), .memData(memData), .ioValid(ioValid), .ioData(ioData),
        .err(memErr)
    );

    pcControl pcControl0 (
        .instr(instr), .ctrl(ctrl), .pcNext(pcNext), .immVal(immVal),
        .readData1(readData1), .zero(zero), .neg(neg), .pc(pc)
    );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Power-on reset over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/procAssert.sv ====
`timescale 1ns/10ps
`default_nettype none

module procAssert (
    input logic clk,
    input logic rst,
    input logic ioValid,
    input logic halted,
    input logic err
);

    // One output store gives exactly one pulse
    ioSinglePulse: assert property (@(posedge clk) disable iff (rst) ioValid |=> !ioValid)
        else $error("ioValid was high for two cycles in a row");

    // Sticky status flags only clear through reset
    haltedSticky: assert property (@(posedge clk) disable iff (rst) $fell(halted) |-> $past(rst))
        else $error("halted fell without a reset");

    errSticky: assert property (@(posedge clk) disable iff (rst) $fell(err) |-> $past(rst))
        else $error("err fell without a reset");

    resetClean: assert property (@(posedge clk) $fell(rst) |-> !ioValid && !halted && !err)
        else $error("a status output was high in the first cycle after reset");

endmodule

bind proc procAssert checks0 (
    .clk(clk),
    .rst(rst),
    .ioValid(ioValid),
    .halted(halted),
    .err(err)
);

`default_nettype wire

// ==== verification/procTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module procTb;
    import procPkg::*;

    // Order keeps the low two bits equal to the funct or opcode low bits
    typedef enum logic [4:0] {
        tAdd, tSub, tXor, tAndn, tRol, tSll, tRor, tSrl,
        tAddi, tSubi, tXori, tAndni, tSeq, tSlt, tConst, tMem,
        tBeqz, tBnez, tBltz, tBgez, tJ, tJal, tHalt, tIllegal, tOddLd
    } testKindT;

    typedef struct packed {
        testKindT         kind;
        logic             rnd;
        logic [dataW-1:0] a;
        logic [dataW-1:0] b;
        logic [dataW-1:0] exp;
    } entryT;

    localparam int imemWords = 256;
    localparam int progAddrW = $clog2(imemWords);
    localparam int bodyStart = 6;
    localparam int waitLimit = 200;
    localparam logic [dataW-1:0] markNot   = 16'h0011;
    localparam logic [dataW-1:0] markTaken = 16'h0022;
    localparam logic [dataW-1:0] markRet   = 16'h0033;
    localparam logic [dataW-1:0] haltWord  = 16'h0000;

    logic                 clk;
    logic                 porRst;
    logic                 loadRst;
    logic                 rst;
    logic                 progWe;
    logic [progAddrW-1:0] progAddr;
    logic [dataW-1:0]     progData;
    logic                 ioValid;
    logic [dataW-1:0]     ioData;
    logic                 halted;
    logic                 err;
    logic [dataW-1:0]     prog [$];
    entryT                vectors [$];
    logic [dataW-1:0]     rngState = 16'd43672;

    assign rst = porRst | loadRst;

    clockGen clkGen0 (.clk(clk), .rst(porRst));

    proc #(.imemWords(imemWords), .dmemWords(256)) u_dut (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .ioValid(ioValid), .ioData(ioData), .halted(halted), .err(err)
    );

    function automatic logic [dataW-1:0] xorshift16(input logic [dataW-1:0] x);
        logic [dataW-1:0] y;
        y = x ^ (x << 7);
        y = y ^ (y >> 9);
        y = y ^ (y << 8);
        return y;
    endfunction

    // I-format 1 and R-format share this layout, R puts {rd, funct} in lo
    function automatic logic [dataW-1:0] encI(input logic [4:0] op, input logic [2:0] rs,
                                              input logic [2:0] rt, input logic [4:0] lo);
        return {op, rs, rt, lo};
    endfunction

    function automatic logic [dataW-1:0] encB(input logic [4:0] op, input logic [2:0] rs,
                                              input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    // Expected first output value, from the ISA rules
    function automatic logic [dataW-1:0] refResult(input entryT e);
        logic [dataW-1:0] sImm;
        logic [dataW-1:0] zImm;
        int               sh;
        sImm = {{11{e.b[4]}}, e.b[4:0]};
        zImm = {11'b0, e.b[4:0]};
        sh   = int'(e.b[3:0]);
        case (e.kind)
            tAdd:    return e.a + e.b;
            tSub:    return e.b - e.a;
            tXor:    return e.a ^ e.b;
            tAndn:   return e.a & ~e.b;
            tSll:    return e.a << sh;
            tSrl:    return e.a >> sh;
            tRol:    return (e.a << sh) | (e.a >> (16 - sh));
            tRor:    return (e.a >> sh) | (e.a << (16 - sh));
            tSeq:    return dataW'(e.a == e.b);
            // Mixed signs decide by the sign bit alone
            tSlt:    return (e.a[15] != e.b[15]) ? dataW'(e.a[15]) : dataW'(e.a < e.b);
            tAddi:   return e.a + sImm;
            tSubi:   return sImm - e.a;
            tXori:   return e.a ^ zImm;
            tAndni:  return e.a & ~zImm;
            tBeqz:   return (e.a == '0) ? markTaken : markNot;
            tBnez:   return (e.a != '0) ? markTaken : markNot;
            tBltz:   return e.a[15] ? markTaken : markNot;
            tBgez:   return !e.a[15] ? markTaken : markNot;
            tJ:      return markTaken;
            // Link is the byte address right after JAL
            tJal:    return dataW'(2 * (bodyStart + 2));
            default: return e.a;
        endcase
    endfunction

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkData(input string name, input logic [dataW-1:0] expected,
                             input logic [dataW-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic waitIo(output logic [dataW-1:0] value);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > waitLimit) begin
                $display("Timed out waiting for an output store on ioValid");
                abortRun();
            end
        end while (!ioValid);
        value = ioData;
    endtask

    task automatic waitHalted();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            checkFlag("ioValid", 1'b0, ioValid);
            if (n > waitLimit) begin
                $display("Timed out waiting for halted after the last output");
                abortRun();
            end
        end while (!halted);
    endtask

    task automatic addEntry(input testKindT kind, input logic rnd,
                            input logic [dataW-1:0] a, input logic [dataW-1:0] b);
        entryT e;
        e.kind = kind;
        e.rnd  = rnd;
        e.a    = a;
        e.b    = b;
        e.exp  = '0;
        vectors.push_back(e);
    endtask

    task automatic buildProgram(input entryT e);
        prog.delete();
        // r1 = a, r2 = b, r6 = output address
        prog.push_back(encB(opLbi, 3'd1, e.a[15:8]));
        prog.push_back(encB(opSlbi, 3'd1, e.a[7:0]));
        prog.push_back(encB(opLbi, 3'd2, e.b[15:8]));
        prog.push_back(encB(opSlbi, 3'd2, e.b[7:0]));
        prog.push_back(encB(opLbi, 3'd6, 8'hFF));
        prog.push_back(encB(opSlbi, 3'd6, 8'h00));
        case (e.kind)
            tAdd, tSub, tXor, tAndn: prog.push_back(encI(opAlu, 3'd1, 3'd2, {3'd3, e.kind[1:0]}));
            tRol, tSll, tRor, tSrl: prog.push_back(encI(opShift, 3'd1, 3'd2, {3'd3, e.kind[1:0]}));
            tAddi, tSubi, tXori, tAndni: prog.push_back(encI({3'b010, e.kind[1:0]}, 3'd1, 3'd3,
                                                              e.b[4:0]));
            tSeq, tSlt: prog.push_back(encI({3'b111, e.kind[1:0]}, 3'd1, 3'd2, {3'd3, 2'b00}));
            tConst: begin
                prog.push_back(encB(opLbi, 3'd3, e.a[15:8]));
                prog.push_back(encB(opSlbi, 3'd3, e.a[7:0]));
            end
            tMem: begin
                prog.push_back(encI(opSt, 3'd2, 3'd1, 5'd0));
                prog.push_back(encI(opLd, 3'd2, 3'd3, 5'd0));
            end
            tBeqz, tBnez, tBltz, tBgez, tJ: begin
                prog.push_back(encB(opLbi, 3'd4, markNot[7:0]));
                prog.push_back(encB(opLbi, 3'd5, markTaken[7:0]));
                if (e.kind == tJ) begin
                    // Skips the first store only
                    prog.push_back(encB(opJ, 3'd0, 8'd2));
                end else begin
                    // Taken skips the first store and its HALT
                    prog.push_back(encB({3'b011, e.kind[1:0]}, 3'd1, 8'd4));
                end
                prog.push_back(encI(opSt, 3'd6, 3'd4, 5'd0));
                if (e.kind != tJ) begin
                    prog.push_back(haltWord);
                end
                prog.push_back(encI(opSt, 3'd6, 3'd5, 5'd0));
                prog.push_back(haltWord);
            end
            tJal: begin
                prog.push_back(encB(opLbi, 3'd5, markRet[7:0]));
                prog.push_back(encB(opJal, 3'd0, 8'd4));
                prog.push_back(encI(opSt, 3'd6, 3'd5, 5'd0));
                prog.push_back(haltWord);
                prog.push_back(encI(opSt, 3'd6, 3'd7, 5'd0));
                prog.push_back(encB(opJr, 3'd7, 8'd0));
            end
            tHalt: begin
                prog.push_back(haltWord);
                prog.push_back(encI(opSt, 3'd6, 3'd1, 5'd0));
            end
            tIllegal: prog.push_back(encB(5'b00010, 3'd0, 8'd0));
            default: prog.push_back(encI(opLd, 3'd1, 3'd3, 5'd1));
        endcase
        if (e.kind <= tMem || e.kind >= tIllegal) begin
            if (e.kind <= tMem) begin
                prog.push_back(encI(opSt, 3'd6, 3'd3, 5'd0));
            end
            prog.push_back(haltWord);
        end
    endtask

    task automatic runEntry(input entryT e);
        logic [dataW-1:0] got;
        int               nOut;
        buildProgram(e);
        @(posedge clk);
        loadRst <= 1'b1;
        foreach (prog[i]) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= progAddrW'(i);
            progData <= prog[i];
        end
        @(posedge clk);
        progWe  <= 1'b0;
        loadRst <= 1'b0;
        @(negedge clk);
        checkFlag("halted", 1'b0, halted);
        checkFlag("err", 1'b0, err);
        checkFlag("ioValid", 1'b0, ioValid);
        nOut = (e.kind == tJal) ? 2 : ((e.kind < tHalt) ? 1 : 0);
        for (int k = 0; k < nOut; k++) begin
            waitIo(got);
            checkData("ioData", (k == 0) ? e.exp : markRet, got);
        end
        waitHalted();
        checkFlag("err", e.kind >= tIllegal, err);
        // Frozen PC, so nothing more may come out
        repeat (20) begin
            @(negedge clk);
            checkFlag("ioValid", 1'b0, ioValid);
            checkFlag("halted", 1'b1, halted);
        end
    endtask

    initial begin
        entryT e;
        loadRst  = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        for (int k = 0; k <= int'(tSlt); k++) begin
            addEntry(testKindT'(k), 1'b1, '0, '0);
            addEntry(testKindT'(k), 1'b1, '0, '0);
        end
        addEntry(tSlt, 1'b0, 16'h8000, 16'h0001);
        addEntry(tSeq, 1'b0, 16'h5A5A, 16'h5A5A);
        addEntry(tRol, 1'b0, 16'h8001, 16'h0000);
        addEntry(tSubi, 1'b0, 16'h0003, 16'h0010);
        addEntry(tConst, 1'b1, '0, '0);
        addEntry(tMem, 1'b1, '0, '0);
        addEntry(tBeqz, 1'b0, 16'h0000, '0);
        addEntry(tBeqz, 1'b0, 16'h1234, '0);
        addEntry(tBnez, 1'b0, 16'h0000, '0);
        addEntry(tBnez, 1'b0, 16'h0001, '0);
        addEntry(tBltz, 1'b0, 16'h8000, '0);
        addEntry(tBltz, 1'b0, 16'h7FFF, '0);
        addEntry(tBgez, 1'b0, 16'h0000, '0);
        addEntry(tBgez, 1'b0, 16'hFFFF, '0);
        addEntry(tJ, 1'b0, '0, '0);
        addEntry(tJal, 1'b0, '0, '0);
        addEntry(tIllegal, 1'b0, '0, '0);
        addEntry(tOddLd, 1'b0, 16'h0010, '0);
        // Runs last so the err left by the odd LD must clear with its reset
        addEntry(tHalt, 1'b0, 16'h0042, '0);
        foreach (vectors[i]) begin
            e = vectors[i];
            if (e.rnd) begin
                rngState = xorshift16(rngState);
                e.a      = rngState;
                rngState = xorshift16(rngState);
                e.b      = rngState;
            end
            // Even data address inside data memory
            if (e.kind == tMem) begin
                e.b = e.b & 16'h01FE;
            end
            e.exp      = refResult(e);
            vectors[i] = e;
        end
        foreach (vectors[i]) begin
            runEntry(vectors[i]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/procPkg.sv
src/fetch.sv
src/control.sv
src/decode.sv
src/execute.sv
src/dataMem.sv
src/pcControl.sv
src/proc.sv
verification/clockGen.sv
verification/procAssert.sv
verification/procTb.sv

// ==== Makefile ====
# Verilator build for the single-cycle processor testbench

TOP       ?= procTb
SIM_DIR   ?= obj_dir
FILELIST  ?= all.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

# A failing check ends the simulation with a nonzero exit status
run: compile
	./$(SIM_DIR)/V$(TOP)

clean:
	rm -rf $(SIM_DIR)
